// File: Makefile
# Verilator build and run of the frame packer testbench

VERILATOR ?= verilator
TOP ?= frame_top_tb
LOG ?= sim.log
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000
FAIL_MSG = FAIL: see errors above

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
verilog/frame_pkg.sv
verilog/fifo.sv
verilog/frame_ctrl.sv
verilog/frame_checksum.sv
verilog/frame_emitter.sv
verilog/frame_top.sv
tests/frame_top_checker.sv
tests/frame_top_tb.sv

// File: tests/frame_top_checker.sv
`default_nettype none

module frame_top_checker (
	input wire clk,
	input wire rst,
	input wire full,
	input wire empty,
	input wire frame_pkg::count_t level,	// FIFO occupancy
	input wire out_valid,
	input wire out_last,
	input wire almost_full	// FIFO flag, not a top-level port
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;	// Read by the testbench at the end

	a_flags: assert property (@(posedge clk) disable iff (rst) !(full && empty))
	else begin
		fail_count++;
		$error("full and empty high together");
	end

	a_level: assert property (@(posedge clk) disable iff (rst) level <= frame_pkg::BUF_SIZE)
	else begin
		fail_count++;
		$error("level above FIFO size");
	end

	a_last: assert property (@(posedge clk) disable iff (rst) out_last |-> out_valid)
	else begin
		fail_count++;
		$error("out_last without out_valid");
	end

	// A frame is one unbroken run of strobes up to the checksum
	a_run: assert property (@(posedge clk) disable iff (rst) out_valid && !out_last |=> out_valid)
	else begin
		fail_count++;
		$error("out_valid dropped before out_last");
	end

	a_almost: assert property (@(posedge clk) disable iff (rst)
		almost_full == (level == frame_pkg::BUF_SIZE - 1))
	else begin
		fail_count++;
		$error("almost_full does not match level");
	end

endmodule : frame_top_checker

bind frame_top frame_top_checker u_checker (
	.clk(clk),
	.rst(rst),
	.full(full),
	.empty(empty),
	.level(level),
	.out_valid(out_valid),
	.out_last(out_last),
	.almost_full(u_fifo.buf_almost_full)
);

`default_nettype wire

// File: tests/frame_top_tb.sv
`default_nettype none

module frame_top_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_WRITES = 800;	// Driven writes in the random phase
	localparam int MAX_CYCLES = N_WRITES * 4 + 800;	// Half-rate writes doubled plus overflow and drain

	logic clk = 1'b0;
	logic rst;
	logic wr_en;
	frame_pkg::word_t wr_data;
	frame_pkg::count_t frame_len;
	logic out_valid;
	frame_pkg::word_t out_data;
	logic out_last;
	frame_pkg::count_t level;
	logic empty;
	logic full;

	frame_pkg::word_t model_q[$];	// Accepted words not yet seen on the output
	logic [15:0] lfsr;	// Random state
	int cycles;
	int value_errors;
	int other_errors;
	int frames;	// Checksum words seen
	int pos;	// Word index inside the frame or 0 between frames
	int data_left;	// Data words still expected in this frame
	frame_pkg::seq_t exp_seq;	// Sequence number of the next header
	frame_pkg::word_t run_sum;	// Model checksum
	string test_name;

	frame_top UUT (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.frame_len(frame_len),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last),
		.level(level),
		.empty(empty),
		.full(full)
	);

	always #50 clk = ~clk;	// 100 ns period

	always @(negedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles in test %s", cycles, test_name);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);	// One step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] got);
		value_errors++;
		$display("error %s %s: expected %h, actual %h", test_name, what, exp, got);
	endtask

	task report_fault(input string msg);
		other_errors++;
		$display("%s: %s", test_name, msg);
	endtask

	// Follows the output stream word by word against the queue
	task monitor_outputs;
		frame_pkg::word_t exp_word;
		logic exp_last;
		string kind;
		exp_word = '0;
		exp_last = 1'b0;
		if (!out_valid) begin
			if (pos != 0)
				report_fault($sformatf("out_valid dropped after %0d words of a frame", pos));
			pos = 0;
		end else begin
			if (pos == 0) begin
				kind = "header";
				exp_word = {16'hA5A5, exp_seq, 4'h0, frame_len};	// Length held at frame start
				data_left = int'(frame_len);
				run_sum = '0;
			end else if (data_left > 0) begin
				kind = "data";
				if (model_q.size() == 0)
					report_fault("data word arrived with the model queue empty");
				else
					exp_word = model_q.pop_front();
				run_sum = run_sum + exp_word;	// Modulo 2^32
				data_left--;
			end else begin
				kind = "checksum";
				exp_word = run_sum;
				exp_last = 1'b1;
				exp_seq++;	// Wraps at 256
				frames++;
			end
			if (out_data !== exp_word)
				report_mismatch(kind, exp_word, out_data);
			if (out_last !== exp_last)
				report_mismatch({kind, " out_last"}, 32'(exp_last), 32'(out_last));
			pos = exp_last ? 0 : pos + 1;
		end
	endtask

	task tick;
		@(negedge clk);
		monitor_outputs();
	endtask

	task drive_write(input logic en);
		wr_en = en;
		if (en) begin
			wr_data = take_bits(32);
			if (!full)
				model_q.push_back(wr_data);	// Accepted at the next rising edge
		end
	endtask

	// New length only while no frame can start with either value
	task maybe_change_len;
		frame_pkg::count_t new_len;
		new_len = frame_pkg::count_t'(take_bits(3)) + 4'd1;	// 1 to 8
		if (!out_valid && pos == 0 && model_q.size() < int'(frame_len)
			&& model_q.size() < int'(new_len))
			frame_len = new_len;
	endtask

	initial begin
		int n;
		int target;
		rst = 1'b1;
		wr_en = 1'b0;
		wr_data = '0;
		frame_len = '0;
		lfsr = 16'd99;
		exp_seq = '0;
		test_name = "reset";
		repeat (5) tick();
		rst = 1'b0;
		tick();
		if (out_valid !== 1'b0)
			report_mismatch("out_valid", 32'd0, 32'(out_valid));
		if (level !== 4'd0)
			report_mismatch("level", 32'd0, 32'(level));
		if (empty !== 1'b1)
			report_mismatch("empty", 32'd1, 32'(empty));
		if (full !== 1'b0)
			report_mismatch("full", 32'd0, 32'(full));

		test_name = "overflow";	// frame_len 0 holds everything back
		for (n = 0; n < 12; n++) begin
			drive_write(1'b1);
			tick();
		end
		drive_write(1'b0);
		tick();
		if (full !== 1'b1)
			report_mismatch("full", 32'd1, 32'(full));
		if (level !== 4'd8)
			report_mismatch("level", 32'd8, 32'(level));
		if (frames != 0 || pos != 0)
			report_fault("output appeared while frame_len was 0");
		frame_len = 4'd8;
		target = frames + 1;
		while (frames < target)
			tick();
		if (level !== 4'd0)
			report_mismatch("level after frame", 32'd0, 32'(level));	// All 8 stored words read out

		test_name = "random";
		n = 0;
		while (n < N_WRITES) begin
			drive_write(take_bits(1) == 1);
			if (wr_en)
				n++;
			maybe_change_len();
			tick();
		end
		drive_write(1'b0);

		test_name = "drain";
		while (out_valid || pos != 0 || model_q.size() >= int'(frame_len))
			tick();
		frame_len = 4'd1;
		while (model_q.size() != 0 || pos != 0)
			tick();
		tick();
		tick();
		if (empty !== 1'b1)
			report_mismatch("empty", 32'd1, 32'(empty));
		if (level !== 4'd0)
			report_mismatch("level", 32'd0, 32'(level));

		$display("value errors %0d, other errors %0d, assertion failures %0d, frames %0d",
			value_errors, other_errors, UUT.u_checker.fail_count, frames);
		if (value_errors + other_errors + UUT.u_checker.fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule : frame_top_tb

`default_nettype wire

// File: verilog/fifo.sv
`default_nettype none

module fifo #(
	parameter int BUF_WIDTH = frame_pkg::BUF_WIDTH,	// 2^BUF_WIDTH entries
	parameter int DATA_WIDTH = frame_pkg::DATA_WIDTH	// Word width
) (
	input wire clk,
	input wire rst,
	input wire [DATA_WIDTH-1:0] buf_in,	// Word to push
	input wire wr_en,	// Push strobe
	input wire rd_en,	// Pop strobe
	output logic [DATA_WIDTH-1:0] buf_out,	// Head word, valid while popping
	output logic buf_empty,
	output logic buf_full,
	output logic buf_almost_full,	// One slot left
	output logic [BUF_WIDTH:0] fifo_counter	// Words held
);

	logic [DATA_WIDTH-1:0] buf_mem [(1 << BUF_WIDTH)];	// Storage, no reset
	logic [BUF_WIDTH-1:0] wr_ptr;	// Next slot to write, wraps
	logic [BUF_WIDTH-1:0] rd_ptr;	// Next slot to read, wraps
	logic wr_ok;	// Push really happens
	logic rd_ok;	// Pop really happens

	// Flags decoded from the counter
	always_comb begin
		buf_empty = (fifo_counter == '0);
		buf_full = (fifo_counter == {1'b1, {BUF_WIDTH{1'b0}}});	// Exactly 2^BUF_WIDTH
		buf_almost_full = (fifo_counter == {1'b0, {BUF_WIDTH{1'b1}}});	// One below full
	end

	assign wr_ok = wr_en && !buf_full;	// Write while full is dropped
	assign rd_ok = rd_en && !buf_empty;	// Internal guard against underflow

	// Occupancy count
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fifo_counter <= '0;
		end else if (wr_ok && rd_ok) begin
			fifo_counter <= fifo_counter;	// Push and pop cancel
		end else if (wr_ok) begin
			fifo_counter <= fifo_counter + 1'b1;
		end else if (rd_ok) begin
			fifo_counter <= fifo_counter - 1'b1;
		end
	end

	// Read data straight from memory, zero when not popping
	always_comb begin
		if (rd_ok)
			buf_out = buf_mem[rd_ptr];
		else
			buf_out = '0;
	end

	always_ff @(posedge clk) begin
		if (wr_ok)
			buf_mem[wr_ptr] <= buf_in;	// Store at write pointer
	end

	// Pointers
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;	// Natural wrap at 2^BUF_WIDTH
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule : fifo

`default_nettype wire

// File: verilog/frame_checksum.sv
`default_nettype none

module frame_checksum (
	input wire clk,
	input wire rst,
	input wire csum_clear,	// Header cycle, start a new sum
	input wire add_en,	// Data word present on data
	input wire frame_pkg::word_t data,	// Word read out of the FIFO
	output frame_pkg::word_t sum	// Running sum of the frame so far
);

	// Registered sum, so in the checksum cycle it already holds
	// the last data word of the frame
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sum <= '0;
		end else if (csum_clear) begin
			sum <= '0;
		end else if (add_en) begin
			sum <= sum + data;	// Wraps modulo 2^32
		end
	end

endmodule : frame_checksum

`default_nettype wire

// File: verilog/frame_ctrl.sv
`default_nettype none

module frame_ctrl (
	input wire clk,
	input wire rst,
	input wire frame_pkg::count_t frame_len,	// Requested length, 0 holds frames
	input wire frame_pkg::count_t level,	// FIFO occupancy
	output logic rd_en,	// Pop one word this cycle
	output frame_pkg::word_sel_t sel,	// Word kind for the emitter
	output logic csum_clear,	// Restart the running sum
	output frame_pkg::count_t cur_len	// Length of the frame in flight
);

	frame_pkg::frame_state_t state;	// Current state
	frame_pkg::count_t remain;	// Data words still to read
	logic start;	// Enough words queued for a frame

	// A frame starts only when all its words are already in the FIFO,
	// so the reads in ST_DATA never find it empty
	assign start = (frame_len != '0) && (level >= frame_len);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= frame_pkg::ST_IDLE;
			cur_len <= '0;
			remain <= '0;
		end else begin
			case (state)
				frame_pkg::ST_IDLE: begin
					if (start) begin
						cur_len <= frame_len;	// Length fixed for the whole frame
						remain <= frame_len;
						state <= frame_pkg::ST_HDR;
					end
				end
				frame_pkg::ST_HDR: begin
					state <= frame_pkg::ST_DATA;	// Length is never 0 here
				end
				frame_pkg::ST_DATA: begin
					remain <= remain - 1'b1;
					if (remain == 4'd1)
						state <= frame_pkg::ST_SUM;	// Last read this cycle
				end
				frame_pkg::ST_SUM: begin
					state <= frame_pkg::ST_IDLE;	// Always one idle cycle between frames
				end
				default: begin
					state <= frame_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Datapath controls follow the state directly
	always_comb begin
		rd_en = 1'b0;
		csum_clear = 1'b0;
		sel = frame_pkg::SEL_NONE;
		case (state)
			frame_pkg::ST_HDR: begin
				sel = frame_pkg::SEL_HDR;
				csum_clear = 1'b1;	// Sum starts fresh for this frame
			end
			frame_pkg::ST_DATA: begin
				sel = frame_pkg::SEL_DATA;
				rd_en = 1'b1;	// One word per cycle
			end
			frame_pkg::ST_SUM: begin
				sel = frame_pkg::SEL_SUM;
			end
			default: begin
				sel = frame_pkg::SEL_NONE;
			end
		endcase
	end

endmodule : frame_ctrl

`default_nettype wire

// File: verilog/frame_emitter.sv
`default_nettype none

module frame_emitter (
	input wire clk,
	input wire rst,
	input wire frame_pkg::word_sel_t sel,	// Which word to send
	input wire frame_pkg::count_t len,	// Frame length for the header
	input wire frame_pkg::word_t data,	// FIFO read data
	input wire frame_pkg::word_t sum,	// Checksum of the frame
	output logic out_valid,	// One strobe per word
	output frame_pkg::word_t out_data,
	output logic out_last	// High with the checksum word
);

	frame_pkg::seq_t seq;	// Sequence number of the current frame
	frame_pkg::word_t next_word;	// Word to register this cycle

	// Word formatting
	always_comb begin
		case (sel)
			frame_pkg::SEL_HDR: next_word = {frame_pkg::HDR_MARK, seq, 4'b0000, len};
			frame_pkg::SEL_DATA: next_word = data;
			frame_pkg::SEL_SUM: next_word = sum;
			default: next_word = '0;
		endcase
	end

	// Strobes and sequence counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
			seq <= '0;
		end else begin
			out_valid <= (sel != frame_pkg::SEL_NONE);
			out_last <= (sel == frame_pkg::SEL_SUM);
			if (sel == frame_pkg::SEL_SUM)
				seq <= seq + 1'b1;	// Next header gets the new number, wraps at 256
		end
	end

	always_ff @(posedge clk) begin
		out_data <= next_word;	// Payload register
	end

endmodule : frame_emitter

`default_nettype wire

// File: verilog/frame_pkg.sv
`default_nettype none

package frame_pkg;

	localparam int BUF_WIDTH = 3;	// FIFO address bits
	localparam int DATA_WIDTH = 32;	// Stream word width
	localparam int BUF_SIZE = 1 << BUF_WIDTH;	// FIFO entries

	typedef logic [DATA_WIDTH-1:0] word_t;	// Stream word
	typedef logic [BUF_WIDTH:0] count_t;	// Occupancy 0..8, also frame length
	typedef logic [7:0] seq_t;	// Frame sequence number

	localparam logic [15:0] HDR_MARK = 16'hA5A5;	// Upper half of every header

	// Kind of word the emitter registers this cycle
	typedef enum logic [1:0] {
		SEL_NONE,	// Nothing to send
		SEL_HDR,	// Header word
		SEL_DATA,	// Word read out of the FIFO
		SEL_SUM	// Checksum word, ends the frame
	} word_sel_t;

	// Frame controller states
	typedef enum logic [1:0] {
		ST_IDLE,	// Wait for a full frame in the FIFO
		ST_HDR,	// One cycle, header
		ST_DATA,	// Length cycles, FIFO reads
		ST_SUM	// One cycle, checksum
	} frame_state_t;

endpackage

`default_nettype wire

// File: verilog/frame_top.sv
`default_nettype none

module frame_top (
	input wire clk,
	input wire rst,
	input wire wr_en,	// Input word strobe
	input wire frame_pkg::word_t wr_data,
	input wire frame_pkg::count_t frame_len,	// Sampled at frame start
	output logic out_valid,
	output frame_pkg::word_t out_data,
	output logic out_last,	// Checksum word
	output frame_pkg::count_t level,	// FIFO occupancy
	output logic empty,
	output logic full	// Writes are dropped while high
);

	logic rd_en;	// Controller pops a word
	logic csum_clear;	// Header cycle
	frame_pkg::word_sel_t sel;	// Word kind to the emitter
	frame_pkg::count_t cur_len;	// Latched frame length
	frame_pkg::word_t rd_data;	// FIFO head during reads
	frame_pkg::word_t sum;	// Running checksum

	fifo #(
		.BUF_WIDTH(frame_pkg::BUF_WIDTH),
		.DATA_WIDTH(frame_pkg::DATA_WIDTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.buf_in(wr_data),
		.wr_en(wr_en),
		.rd_en(rd_en),
		.buf_out(rd_data),
		.buf_empty(empty),
		.buf_full(full),
		.buf_almost_full(),	// Only watched by the checker
		.fifo_counter(level)
	);

	frame_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.frame_len(frame_len),
		.level(level),
		.rd_en(rd_en),
		.sel(sel),
		.csum_clear(csum_clear),
		.cur_len(cur_len)
	);

	frame_checksum u_csum (
		.clk(clk),
		.rst(rst),
		.csum_clear(csum_clear),
		.add_en(rd_en),	// Every read is a data word
		.data(rd_data),
		.sum(sum)
	);

	frame_emitter u_emit (
		.clk(clk),
		.rst(rst),
		.sel(sel),
		.len(cur_len),
		.data(rd_data),
		.sum(sum),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last)
	);

endmodule : frame_top

`default_nettype wire
